/* verilog/core_arch_pkg.sv */
// ----------------------------------------------------------------------
// Core architecture package
// Widths and default sizing shared by the core blocks
// ----------------------------------------------------------------------

`default_nettype none

package core_arch_pkg;

  // --------------------------------------------------------------------
  // Address width
  // --------------------------------------------------------------------

  // One machine word
  localparam int ADDR_WIDTH = 32;

  // Redirect target address
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // --------------------------------------------------------------------
  // Default sizing
  // --------------------------------------------------------------------

  // Number of squash sources, e.g. branch units
  localparam int DEFAULT_NUM_ARB = 2;

  // Sequence number width, wraps at 2**bits
  localparam int DEFAULT_SEQ_NUM_BITS = 5;

endpackage

`default_nettype wire

/* verilog/squash_pkg.sv */
// ----------------------------------------------------------------------
// Squash unit package
// Types local to the first-level squash logic
// ----------------------------------------------------------------------

`default_nettype none

package squash_pkg;

  // --------------------------------------------------------------------
  // Age tracker state
  // --------------------------------------------------------------------

  // TRK_IDLE
  //   No commit since reset, reference sits at zero
  // TRK_TRACKING
  //   At least one commit seen, reference follows the commit stream
  //
  // Also lets later debug and flush logic tell a fresh pipeline
  // from a running one
  typedef enum logic {
    TRK_IDLE     = 1'b0,
    TRK_TRACKING = 1'b1
  } age_trk_state_e;

  // Single bit state, one flop in the tracker
  // Reset value is TRK_IDLE

endpackage

`default_nettype wire

/* verilog/seq_age_tracker.sv */
// ----------------------------------------------------------------------
// Sequence age tracker
// Follows the commit stream and keeps the age reference point,
// one past the last committed sequence number
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module seq_age_tracker
  import squash_pkg::*;
#(
  parameter int SEQ_NUM_BITS = 5
) (
  input  wire logic                    clk,
  input  wire logic                    rst,

  // Commit notification, strobe and sequence number only
  input  wire logic                    commit_val,
  input  wire logic [SEQ_NUM_BITS-1:0] commit_seq_num,

  // Reference point for the arbiter age compare
  output logic      [SEQ_NUM_BITS-1:0] age_ref
);

  // --------------------------------------------------------------------
  // State and reference registers
  // --------------------------------------------------------------------

  age_trk_state_e            state_q;
  logic [SEQ_NUM_BITS-1:0]   ref_q;
  logic [SEQ_NUM_BITS-1:0]   commit_next;

  // One past the committed instruction, wraps naturally
  assign commit_next = commit_seq_num + SEQ_NUM_BITS'(1);

  // Tracker state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= TRK_IDLE;
    end else if (commit_val) begin
      state_q <= TRK_TRACKING;
    end
  end

  // Reference only meaningful once tracking
  always_ff @(posedge clk) begin
    if (commit_val) begin
      ref_q <= commit_next;
    end
  end

  // --------------------------------------------------------------------
  // Reference output
  // --------------------------------------------------------------------

  // Idle pipeline compares against zero
  // A commit in cycle N shows here from cycle N+1
  assign age_ref = (state_q == TRK_TRACKING) ? ref_q : '0;

endmodule

`default_nettype wire

/* verilog/squash_arbiter.sv */
// ----------------------------------------------------------------------
// Squash arbiter
// Picks the oldest valid squash by wrapped age and registers it
// as a one-cycle grant
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module squash_arbiter
  import core_arch_pkg::*;
#(
  parameter int NUM_ARB      = 2,
  parameter int SEQ_NUM_BITS = 5
) (
  input  wire logic                                 clk,
  input  wire logic                                 rst,

  // Squash requests, one slice per requester
  input  wire logic  [NUM_ARB-1:0]                  arb_val,
  input  wire logic  [NUM_ARB-1:0][SEQ_NUM_BITS-1:0] arb_seq_num,
  input  wire addr_t [NUM_ARB-1:0]                  arb_target,

  // Reference point from the age tracker, same cycle as the requests
  input  wire logic  [SEQ_NUM_BITS-1:0]             age_ref,

  // Granted squash
  output logic                                      gnt_val,
  output logic       [SEQ_NUM_BITS-1:0]             gnt_seq_num,
  output addr_t                                     gnt_target
);

  // --------------------------------------------------------------------
  // Wrapped age per requester
  // --------------------------------------------------------------------

  // Distance from the reference, modulo 2**SEQ_NUM_BITS
  // Smaller age means older instruction
  logic [NUM_ARB-1:0][SEQ_NUM_BITS-1:0] req_age;

  always_comb begin
    for (int i = 0; i < NUM_ARB; i++) begin
      req_age[i] = arb_seq_num[i] - age_ref;
    end
  end

  // --------------------------------------------------------------------
  // Oldest selection
  // --------------------------------------------------------------------

  logic                    sel_found;
  logic [SEQ_NUM_BITS-1:0] sel_age;
  logic [SEQ_NUM_BITS-1:0] sel_seq_num;
  addr_t                   sel_target;
  logic                    any_val;

  // Scan upward, strict compare keeps the lowest index on a tie
  always_comb begin
    sel_found   = 1'b0;
    sel_age     = '0;
    sel_seq_num = '0;
    sel_target  = '0;
    for (int i = 0; i < NUM_ARB; i++) begin
      if (arb_val[i] && (!sel_found || (req_age[i] < sel_age))) begin
        sel_found   = 1'b1;
        sel_age     = req_age[i];
        sel_seq_num = arb_seq_num[i];
        sel_target  = arb_target[i];
      end
    end
  end

  // Any squash this cycle yields a grant next cycle
  assign any_val = |arb_val;

  // --------------------------------------------------------------------
  // Grant register
  // --------------------------------------------------------------------

  // Losers are dropped, they are younger than the winner
  // Fields read zero on cycles with no request
  always_ff @(posedge clk) begin
    if (rst) begin
      gnt_val     <= 1'b0;
      gnt_seq_num <= '0;
      gnt_target  <= '0;
    end else begin
      gnt_val     <= any_val;
      gnt_seq_num <= sel_seq_num;
      gnt_target  <= sel_target;
    end
  end

endmodule

`default_nettype wire

/* verilog/squash_unit.sv */
// ----------------------------------------------------------------------
// First-level squash unit
// Forwards only the oldest of the squashes raised in a cycle,
// aged against the commit reference point
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module squash_unit
  import core_arch_pkg::*;
#(
  parameter int NUM_ARB      = DEFAULT_NUM_ARB,
  parameter int SEQ_NUM_BITS = DEFAULT_SEQ_NUM_BITS
) (
  input  wire logic                                 clk,
  input  wire logic                                 rst,

  // Squash requests from the pipeline stages
  input  wire logic  [NUM_ARB-1:0]                  arb_val,
  input  wire logic  [NUM_ARB-1:0][SEQ_NUM_BITS-1:0] arb_seq_num,
  input  wire addr_t [NUM_ARB-1:0]                  arb_target,

  // Commit notification
  input  wire logic                                 commit_val,
  input  wire logic  [SEQ_NUM_BITS-1:0]             commit_seq_num,

  // Oldest squash, one cycle after the requests
  output logic                                      gnt_val,
  output logic       [SEQ_NUM_BITS-1:0]             gnt_seq_num,
  output addr_t                                     gnt_target
);

  // Reference point, tracker to arbiter
  logic [SEQ_NUM_BITS-1:0] age_ref;

  // --------------------------------------------------------------------
  // Age tracker
  // --------------------------------------------------------------------

  seq_age_tracker #(
    .SEQ_NUM_BITS   (SEQ_NUM_BITS)
  ) i_seq_age_tracker (
    .clk            (clk),
    .rst            (rst),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .age_ref        (age_ref)
  );

  // --------------------------------------------------------------------
  // Oldest-first arbiter
  // --------------------------------------------------------------------

  squash_arbiter #(
    .NUM_ARB        (NUM_ARB),
    .SEQ_NUM_BITS   (SEQ_NUM_BITS)
  ) i_squash_arbiter (
    .clk            (clk),
    .rst            (rst),
    .arb_val        (arb_val),
    .arb_seq_num    (arb_seq_num),
    .arb_target     (arb_target),
    .age_ref        (age_ref),
    .gnt_val        (gnt_val),
    .gnt_seq_num    (gnt_seq_num),
    .gnt_target     (gnt_target)
  );

endmodule

`default_nettype wire

/* tb/squash_unit_tb.sv */
// ----------------------------------------------------------------------
// Squash unit testbench
// Random and directed squash traffic checked against an age model
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module squash_unit_tb
  import core_arch_pkg::*;
  import squash_pkg::*;
;

  localparam int NUM_ARB       = 4;
  localparam int SEQ_NUM_BITS  = 5;
  localparam int CLK_PERIOD    = 4;
  localparam int NUM_TESTS     = 6;
  localparam int RANDOM_CYCLES = 300;
  localparam int WATCHDOG_NS   = NUM_TESTS * RANDOM_CYCLES * CLK_PERIOD * 2;

  logic                                 clk;
  logic                                 rst;
  logic [NUM_ARB-1:0]                   arb_val;
  logic [NUM_ARB-1:0][SEQ_NUM_BITS-1:0] arb_seq_num;
  addr_t [NUM_ARB-1:0]                  arb_target;
  logic                                 commit_val;
  logic [SEQ_NUM_BITS-1:0]              commit_seq_num;
  logic                                 gnt_val;
  logic [SEQ_NUM_BITS-1:0]              gnt_seq_num;
  addr_t                                gnt_target;

  // Model of the tracker and the expected grant
  age_trk_state_e                       model_state;
  logic [SEQ_NUM_BITS-1:0]              model_ref;
  logic                                 exp_val;
  logic [SEQ_NUM_BITS-1:0]              exp_seq_num;
  addr_t                                exp_target;

  integer                               seed = 32'h70f5_546c;
  int                                   val_errors;
  int                                   grant_errors;
  logic [31:0]                          rnd;
  logic [NUM_ARB-1:0]                   s_val;
  logic [NUM_ARB-1:0][SEQ_NUM_BITS-1:0] s_seq;
  addr_t [NUM_ARB-1:0]                  s_tgt;

  squash_unit #(
    .NUM_ARB        (NUM_ARB),
    .SEQ_NUM_BITS   (SEQ_NUM_BITS)
  ) i_squash_unit (
    .clk            (clk),
    .rst            (rst),
    .arb_val        (arb_val),
    .arb_seq_num    (arb_seq_num),
    .arb_target     (arb_target),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .gnt_val        (gnt_val),
    .gnt_seq_num    (gnt_seq_num),
    .gnt_target     (gnt_target)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Hard stop if the sequence stalls
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: simulation timed out after %0d ns without finishing", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  // --------------------------------------------------------------------
  // Helpers and compare tasks
  // --------------------------------------------------------------------

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  task automatic check_val(input logic exp);
    if (gnt_val !== exp) begin
      val_errors++;
      $display("CHECK FAILED t=%0t gnt_val expected %0b actual %0b", $time, exp, gnt_val);
    end
  endtask

  task automatic check_grant(input addr_t exp_tgt, input logic [SEQ_NUM_BITS-1:0] exp_seq);
    if (gnt_target !== exp_tgt) begin
      grant_errors++;
      $display("CHECK FAILED t=%0t gnt_target expected %h actual %h",
               $time, exp_tgt, gnt_target);
    end
    if (gnt_seq_num !== exp_seq) begin
      grant_errors++;
      $display("CHECK FAILED t=%0t gnt_seq_num expected %0d actual %0d",
               $time, exp_seq, gnt_seq_num);
    end
  endtask

  // Oldest by wrapped distance from the reference, lowest index on a tie
  // Fields stay zero when nothing is requested
  task automatic predict_grant(input logic [NUM_ARB-1:0] val,
                               input logic [NUM_ARB-1:0][SEQ_NUM_BITS-1:0] seq,
                               input addr_t [NUM_ARB-1:0] tgt);
    logic                    found;
    logic [SEQ_NUM_BITS-1:0] ref_used;
    logic [SEQ_NUM_BITS-1:0] age;
    logic [SEQ_NUM_BITS-1:0] best_age;
    found       = 1'b0;
    best_age    = '0;
    exp_seq_num = '0;
    exp_target  = '0;
    ref_used    = (model_state == TRK_TRACKING) ? model_ref : '0;
    for (int i = 0; i < NUM_ARB; i++) begin
      age = seq[i] - ref_used;
      if (val[i] && (!found || age < best_age)) begin
        found       = 1'b1;
        best_age    = age;
        exp_seq_num = seq[i];
        exp_target  = tgt[i];
      end
    end
    exp_val = found;
  endtask

  // One cycle: check last cycle's grant, drive new inputs, advance the model
  task automatic apply_cycle(input logic [NUM_ARB-1:0] val,
                             input logic [NUM_ARB-1:0][SEQ_NUM_BITS-1:0] seq,
                             input addr_t [NUM_ARB-1:0] tgt,
                             input logic cval,
                             input logic [SEQ_NUM_BITS-1:0] cseq);
    @(negedge clk);
    check_val(exp_val);
    check_grant(exp_target, exp_seq_num);
    arb_val        = val;
    arb_seq_num    = seq;
    arb_target     = tgt;
    commit_val     = cval;
    commit_seq_num = cseq;
    // Same-cycle commit is not yet visible to the compare
    predict_grant(val, seq, tgt);
    if (cval) begin
      model_state = TRK_TRACKING;
      model_ref   = cseq + SEQ_NUM_BITS'(1);
    end
  endtask

  task automatic fill_random(output logic [NUM_ARB-1:0] val,
                             output logic [NUM_ARB-1:0][SEQ_NUM_BITS-1:0] seq,
                             output addr_t [NUM_ARB-1:0] tgt);
    logic [31:0] r;
    for (int i = 0; i < NUM_ARB; i++) begin
      r      = next_random();
      val[i] = r[0];
      seq[i] = r[SEQ_NUM_BITS:1];
      tgt[i] = next_random();
    end
  endtask

  // --------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------

  initial begin
    rst = 1'b1;
    // Busy inputs during reset, none of it may reach the outputs
    arb_val = '1;
    arb_seq_num = '1;
    arb_target = '1;
    commit_val = 1'b1;
    commit_seq_num = SEQ_NUM_BITS'(9);
    model_state = TRK_IDLE;
    model_ref = '0;
    exp_val = 1'b0;
    exp_seq_num = '0;
    exp_target = '0;
    val_errors = 0;
    grant_errors = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_val(1'b0);
    check_grant('0, '0);
    arb_val = '0;
    arb_seq_num = '0;
    arb_target = '0;
    commit_val = 1'b0;
    commit_seq_num = '0;

    // Reset state, idle outputs
    repeat (3) apply_cycle('0, '0, '0, 1'b0, '0);

    // Lone request per index
    for (int i = 0; i < NUM_ARB; i++) begin
      fill_random(s_val, s_seq, s_tgt);
      s_val = '0;
      s_val[i] = 1'b1;
      apply_cycle(s_val, s_seq, s_tgt, 1'b0, '0);
      apply_cycle('0, '0, '0, 1'b0, '0);
    end

    // Reference still zero, the commit seen during reset is dropped
    s_val = 4'b0011;
    s_seq[0] = SEQ_NUM_BITS'(5);
    s_seq[1] = SEQ_NUM_BITS'(12);
    apply_cycle(s_val, s_seq, s_tgt, 1'b0, '0);

    // Random contention, commit-only cycles mixed in
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      rnd = next_random();
      if (rnd[1:0] == 2'b00) begin
        rnd = next_random();
        apply_cycle('0, '0, '0, 1'b1, rnd[SEQ_NUM_BITS-1:0]);
      end else begin
        fill_random(s_val, s_seq, s_tgt);
        apply_cycle(s_val, s_seq, s_tgt, 1'b0, '0);
      end
    end

    // Reference near the top, wrapped small numbers are older
    apply_cycle('0, '0, '0, 1'b1, SEQ_NUM_BITS'(30));
    fill_random(s_val, s_seq, s_tgt);
    s_val = 4'b0011;
    s_seq[0] = SEQ_NUM_BITS'(29);
    s_seq[1] = SEQ_NUM_BITS'(1);
    apply_cycle(s_val, s_seq, s_tgt, 1'b0, '0);
    // Commit alongside requests, old reference still decides
    s_seq[0] = SEQ_NUM_BITS'(0);
    s_seq[1] = SEQ_NUM_BITS'(5);
    apply_cycle(s_val, s_seq, s_tgt, 1'b1, SEQ_NUM_BITS'(0));
    apply_cycle(s_val, s_seq, s_tgt, 1'b0, '0);
    apply_cycle('0, '0, '0, 1'b0, '0);

    // Equal sequence numbers, lowest index wins
    fill_random(s_val, s_seq, s_tgt);
    s_seq = {NUM_ARB{SEQ_NUM_BITS'(7)}};
    apply_cycle(4'b1110, s_seq, s_tgt, 1'b0, '0);
    apply_cycle(4'b1111, s_seq, s_tgt, 1'b0, '0);

    // Back-to-back grants
    repeat (8) begin
      fill_random(s_val, s_seq, s_tgt);
      rnd = next_random();
      s_val[rnd[1:0]] = 1'b1;
      apply_cycle(s_val, s_seq, s_tgt, 1'b0, '0);
    end

    // Flush the last expected grant
    repeat (2) apply_cycle('0, '0, '0, 1'b0, '0);

    $display("Errors: gnt_val %0d, grant fields %0d, total %0d",
             val_errors, grant_errors, val_errors + grant_errors);
    if (val_errors + grant_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
verilog/core_arch_pkg.sv
verilog/squash_pkg.sv
verilog/seq_age_tracker.sv
verilog/squash_arbiter.sv
verilog/squash_unit.sv
tb/squash_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the squash unit testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

set -u

cd "$(dirname "$0")" || {
  echo "Cannot change to the project directory"
  exit 1
}

BUILD_DIR=obj_dir
SIM_BIN=squash_unit_sim
LOG_FILE=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

rm -rf "${BUILD_DIR}" "${LOG_FILE}"

verilator --binary --timing \
  --top-module squash_unit_tb \
  -f project.f \
  -Mdir "${BUILD_DIR}" \
  -o "${SIM_BIN}"
status=$?
if [ ${status} -ne 0 ]; then
  echo "Verilator build failed with status ${status}"
  exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
status=$?
cat "${LOG_FILE}"
if [ ${status} -ne 0 ]; then
  echo "Simulation exited with status ${status}"
  exit 1
fi

if grep -q "Testbench passed" "${LOG_FILE}"; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi
